// File: verilog/fetch_pkg.sv
package fetch_pkg;

	////////////////////
	// l15 return types
	////////////////////
	localparam logic [3:0] ret_load   = 4'b0000;
	localparam logic [3:0] ret_ifill  = 4'b0001;
	localparam logic [3:0] ret_st_ack = 4'b0100;
	localparam logic [3:0] ret_int    = 4'b0111; // interrupt, used as wake-up

	////////////////////
	// request side
	////////////////////
	localparam logic [4:0] rq_ifill     = 5'b10000; // instruction miss / fill
	localparam logic [2:0] rq_size_word = 3'b010;   // 4 bytes

	// first fetch after wake
	localparam logic [31:0] reset_vector = 32'h4000_0000;

	// add x0,x0,x0
	localparam logic [31:0] nop_instr = 32'h0000_0033;

	////////////////////
	// request port fsm
	////////////////////
	localparam logic [1:0] s_req      = 2'd0;
	localparam logic [1:0] s_wait_ack = 2'd1;
	localparam logic [1:0] s_resp     = 2'd2;

endpackage

// File: verilog/fetch_pc_unit.sv
`timescale 1ns/1ps

module fetch_pc_unit
	import fetch_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        redirect,
	input  logic [31:0] redirect_target,
	input  logic        exception_pending,
	input  logic [31:0] epc,
	input  logic        done_pulse,
	input  logic        request_busy,
	output logic [31:0] fetch_addr,
	output logic        fetch_pc_misaligned,
	output logic        misaligned_pulse
);

	logic [31:0] pc;          // address of the next fetch
	logic        pend_valid;  // redirect seen while a request was out
	logic [31:0] pend_target;
	logic [31:0] sel_target;
	logic        redirect_any;
	logic        take_now;
	logic        tgt_mis;

	// exception wins over a branch in the same cycle
	assign sel_target   = exception_pending ? epc : redirect_target;
	assign redirect_any = redirect | exception_pending;
	assign take_now     = redirect_any & ~request_busy;
	assign tgt_mis      = |sel_target[1:0];

	assign fetch_pc_misaligned = |pc[1:0]; // pending target landed unaligned
	assign fetch_addr          = take_now ? sel_target : pc;

	// immediate bad target, or a stale unaligned pc once the port is idle
	assign misaligned_pulse = take_now ? tgt_mis : (fetch_pc_misaligned & ~request_busy);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pc         <= reset_vector;
			pend_valid <= 1'b0;
		end
		else if (take_now)
		begin
			// unaligned target never reaches memory, skip to the next word
			pc         <= tgt_mis ? {sel_target[31:2], 2'b00} + 32'd4 : sel_target;
			pend_valid <= 1'b0;
		end
		else if (misaligned_pulse)
			pc <= {pc[31:2], 2'b00} + 32'd4;
		else if (done_pulse)
		begin
			if (redirect_any)
				pc <= sel_target;   // newest redirect wins
			else if (pend_valid)
				pc <= pend_target;
			else
				pc <= pc + 32'd4;
			pend_valid <= 1'b0;
		end
		else if (redirect_any)
			pend_valid <= 1'b1;
	end

	// target held until the outstanding response is back
	always_ff @(posedge clk)
	begin
		if (redirect_any && request_busy && !done_pulse)
			pend_target <= sel_target;
	end

endmodule

// File: verilog/fetch_wake_ctrl.sv
`timescale 1ns/1ps

module fetch_wake_ctrl
	import fetch_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       l15_ret_val,
	input  logic [3:0] l15_ret_type,
	input  logic       redirect_any,
	input  logic       request_busy,
	input  logic       done_pulse,
	output logic       awake,
	output logic       discard_pending
);

	logic int_seen;  // wake-up packet on the return bus
	logic go_stale;  // redirect overtakes a request still out

	assign int_seen = l15_ret_val && (l15_ret_type == ret_int);

	// a redirect in the completion cycle itself does not hit that response
	assign go_stale = redirect_any && request_busy && !done_pulse;

	////////////////////
	// wake latch
	////////////////////
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			awake <= 1'b0;
		else if (int_seen)
			awake <= 1'b1; // sticky until reset
	end

	////////////////////
	// stale response
	////////////////////
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			discard_pending <= 1'b0;
		else if (done_pulse)
			discard_pending <= 1'b0;     // stale word consumed
		else if (go_stale)
			discard_pending <= 1'b1;
	end

endmodule

// File: verilog/fetch_l15_port.sv
`timescale 1ns/1ps

module fetch_l15_port
	import fetch_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic [31:0] fetch_addr,
	input  logic        fetch_pc_misaligned,
	input  logic        misaligned_pulse,
	input  logic        awake,
	input  logic        discard_pending,
	input  logic        stall,
	// l15 request
	input  logic        l15_ack,
	input  logic        l15_header_ack,
	output logic [4:0]  l15_rqtype,
	output logic [2:0]  l15_size,
	output logic [31:0] l15_address,
	output logic        l15_val,
	// l15 response
	input  logic        l15_ret_val,
	input  logic [3:0]  l15_ret_type,
	input  logic [63:0] l15_ret_data_0,
	input  logic [63:0] l15_ret_data_1,
	output logic        l15_req_ack,
	// to pc unit and decode
	output logic        request_busy,
	output logic        done_pulse,
	output logic [31:0] instr,
	output logic [31:0] instr_pc,
	output logic        instr_valid,
	output logic        instr_misaligned
);

	logic [1:0]  state;
	logic [31:0] req_addr;  // address of the fill in flight
	logic        req_fire;
	logic        val_held;  // presented, header not yet taken
	logic [31:0] sel_word;
	logic [31:0] swapped;
	logic        deliver;

	// request is only presented from the idle state
	assign l15_val      = (state == s_req) &&
		(val_held || (awake && !stall && !fetch_pc_misaligned));
	assign l15_address  = fetch_addr;
	assign l15_rqtype   = rq_ifill;
	assign l15_size     = rq_size_word;
	assign req_fire     = l15_val && l15_header_ack;
	assign request_busy = (state != s_req) || l15_val;

	assign l15_req_ack = l15_ret_val; // every return is taken at once
	assign done_pulse  = (state == s_resp) && l15_ret_val && (l15_ret_type == ret_ifill);
	assign deliver     = done_pulse && !discard_pending;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			state <= s_req;
		else
		begin
			case (state)
				s_req:
					if (req_fire)
						state <= l15_ack ? s_resp : s_wait_ack;
				s_wait_ack:
					if (l15_ack)
						state <= s_resp;
				s_resp:
					if (done_pulse)
						state <= s_req;
				default:
					state <= s_req;
			endcase
		end
	end

	// once raised, val stays up through a stall until the header goes
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			val_held <= 1'b0;
		else
			val_held <= l15_val && !l15_header_ack;
	end

	always_ff @(posedge clk)
	begin
		if (req_fire)
			req_addr <= fetch_addr;
	end

	////////////////////
	// word pick + swap
	////////////////////
	always_comb
	begin
		case (req_addr[3:2])
			2'b00:   sel_word = l15_ret_data_0[63:32];
			2'b01:   sel_word = l15_ret_data_0[31:0];
			2'b10:   sel_word = l15_ret_data_1[63:32];
			default: sel_word = l15_ret_data_1[31:0];
		endcase
	end

	// cache line is big-endian
	assign swapped = {sel_word[7:0], sel_word[15:8], sel_word[23:16], sel_word[31:24]};

	////////////////////
	// instruction out
	////////////////////
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			instr_valid      <= 1'b0;
			instr_misaligned <= 1'b0;
		end
		else
		begin
			instr_valid      <= deliver || misaligned_pulse;
			instr_misaligned <= misaligned_pulse;
		end
	end

	always_ff @(posedge clk)
	begin
		instr <= deliver ? swapped : nop_instr; // nop whenever nothing real
		if (deliver)
			instr_pc <= req_addr;
		else if (misaligned_pulse)
			instr_pc <= fetch_addr; // the offending target
	end

endmodule

// File: verilog/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend (
	input  logic        clk,
	input  logic        nrst,
	input  logic        stall,
	input  logic        redirect,
	input  logic [31:0] redirect_target,
	input  logic        exception_pending,
	input  logic [31:0] epc,
	// l15 request
	output logic [4:0]  l15_rqtype,
	output logic [2:0]  l15_size,
	output logic [31:0] l15_address,
	output logic        l15_val,
	input  logic        l15_ack,
	input  logic        l15_header_ack,
	// l15 response
	input  logic        l15_ret_val,
	input  logic [3:0]  l15_ret_type,
	input  logic [63:0] l15_ret_data_0,
	input  logic [63:0] l15_ret_data_1,
	output logic        l15_req_ack,
	// to decode
	output logic [31:0] instr,
	output logic [31:0] instr_pc,
	output logic        instr_valid,
	output logic        instr_misaligned
);

	logic [31:0] fetch_addr;
	logic        fetch_pc_misaligned;
	logic        misaligned_pulse;
	logic        done_pulse;
	logic        request_busy;
	logic        awake;
	logic        discard_pending;

	////////////////////
	// next fetch address
	////////////////////
	fetch_pc_unit pc_i (
		.clk                 (clk),
		.nrst                (nrst),
		.redirect            (redirect),
		.redirect_target     (redirect_target),
		.exception_pending   (exception_pending),
		.epc                 (epc),
		.done_pulse          (done_pulse),
		.request_busy        (request_busy),
		.fetch_addr          (fetch_addr),
		.fetch_pc_misaligned (fetch_pc_misaligned),
		.misaligned_pulse    (misaligned_pulse)
	);

	fetch_wake_ctrl wake_i (
		.clk             (clk),
		.nrst            (nrst),
		.l15_ret_val     (l15_ret_val),
		.l15_ret_type    (l15_ret_type),
		.redirect_any    (redirect | exception_pending), // either strobe makes in-flight stale
		.request_busy    (request_busy),
		.done_pulse      (done_pulse),
		.awake           (awake),
		.discard_pending (discard_pending)
	);

	////////////////////
	// l15 transducer side
	////////////////////
	fetch_l15_port port_i (
		.clk                 (clk),
		.nrst                (nrst),
		.fetch_addr          (fetch_addr),
		.fetch_pc_misaligned (fetch_pc_misaligned),
		.misaligned_pulse    (misaligned_pulse),
		.awake               (awake),
		.discard_pending     (discard_pending),
		.stall               (stall),
		.l15_ack             (l15_ack),
		.l15_header_ack      (l15_header_ack),
		.l15_rqtype          (l15_rqtype),
		.l15_size            (l15_size),
		.l15_address         (l15_address),
		.l15_val             (l15_val),
		.l15_ret_val         (l15_ret_val),
		.l15_ret_type        (l15_ret_type),
		.l15_ret_data_0      (l15_ret_data_0),
		.l15_ret_data_1      (l15_ret_data_1),
		.l15_req_ack         (l15_req_ack),
		.request_busy        (request_busy),
		.done_pulse          (done_pulse),
		.instr               (instr),
		.instr_pc            (instr_pc),
		.instr_valid         (instr_valid),
		.instr_misaligned    (instr_misaligned)
	);

endmodule

// File: test/fetch_props.sv
`timescale 1ns/1ps

module fetch_props
	import fetch_pkg::*;
(
	input logic        clk,
	input logic        nrst,
	input logic [1:0]  state,
	input logic        l15_val,
	input logic        l15_header_ack,
	input logic [31:0] l15_address,
	input logic        l15_ret_val,
	input logic [3:0]  l15_ret_type,
	input logic        discard_pending
);

	// address must not move under a request that waits for its header
	a_addr_hold: assert property (@(posedge clk) disable iff (!nrst)
		l15_val && !l15_header_ack |=> $stable(l15_address))
		else $error("l15_address changed while waiting for the header ack");

	// a fill return outside s_resp would be lost
	a_ifill_in_resp: assert property (@(posedge clk) disable iff (!nrst)
		l15_ret_val && l15_ret_type == ret_ifill |-> state == s_resp)
		else $error("ifill return arrived with no fetch waiting for it");

	a_discard_owned: assert property (@(posedge clk) disable iff (!nrst)
		discard_pending |-> state != s_req || l15_val)
		else $error("discard flag set with no request outstanding");

endmodule

// File: test/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker
	import fetch_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        stall,
	input  logic        redirect,
	input  logic [31:0] redirect_target,
	input  logic        exception_pending,
	input  logic [31:0] epc,
	input  logic        l15_val,
	input  logic [31:0] l15_address,
	input  logic [4:0]  l15_rqtype,
	input  logic [2:0]  l15_size,
	input  logic        l15_ret_val,
	input  logic [3:0]  l15_ret_type,
	input  logic        l15_req_ack,
	input  logic [31:0] instr,
	input  logic [31:0] instr_pc,
	input  logic        instr_valid,
	input  logic        instr_misaligned,
	output int          errors,
	output int          delivered,
	output int          mis_count
);

	logic [31:0] exp_pc; // pc of the next instruction decode should see
	logic        woke;
	logic        val_prev; // request already presented last cycle

	// memory contents, little-endian word view
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] x;
		x = addr ^ 32'h5A5A_0000;
		return {x[28:0], x[31:29]};
	endfunction

	always @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			exp_pc = reset_vector;
			woke = 1'b0;
			val_prev = 1'b0;
			errors = 0;
			delivered = 0;
			mis_count = 0;
		end
		else
		begin
			if (l15_val && !woke)
			begin
				$display("request issued before the wake-up return");
				errors++;
			end
			if (l15_val && !val_prev && stall)
			begin
				$display("request started while stall was high");
				errors++;
			end
			if (l15_val)
			begin
				if (l15_address[1:0] != 2'b00)
				begin
					$display("ERROR l15_address got %08h expected %08h",
						l15_address, {l15_address[31:2], 2'b00});
					errors++;
				end
				if (l15_rqtype !== rq_ifill)
				begin
					$display("ERROR l15_rqtype got %h expected %h", l15_rqtype, rq_ifill);
					errors++;
				end
				if (l15_size !== rq_size_word)
				begin
					$display("ERROR l15_size got %h expected %h", l15_size, rq_size_word);
					errors++;
				end
			end
			// every return is answered in its own cycle
			if (l15_req_ack !== l15_ret_val)
			begin
				$display("ERROR l15_req_ack got %h expected %h", l15_req_ack, l15_ret_val);
				errors++;
			end
			if (l15_ret_val && l15_ret_type == ret_int)
				woke = 1'b1;
			val_prev = l15_val;

			if (instr_valid)
			begin
				delivered++;
				if (instr_pc !== exp_pc)
				begin
					$display("ERROR instr_pc got %08h expected %08h", instr_pc, exp_pc);
					errors++;
				end
				if (exp_pc[1:0] != 2'b00)
				begin
					mis_count++;
					if (instr_misaligned !== 1'b1 || instr !== nop_instr)
					begin
						$display("ERROR instr_misaligned got %h instr got %08h expected %08h",
							instr_misaligned, instr, nop_instr);
						errors++;
					end
					exp_pc = {exp_pc[31:2], 2'b00} + 32'd4;
				end
				else
				begin
					if (instr_misaligned !== 1'b0 || instr !== mem_word(exp_pc))
					begin
						$display("ERROR instr got %08h expected %08h (misaligned %h)",
							instr, mem_word(exp_pc), instr_misaligned);
						errors++;
					end
					exp_pc = exp_pc + 32'd4;
				end
			end

			// exception beats the branch
			if (exception_pending)
				exp_pc = epc;
			else if (redirect)
				exp_pc = redirect_target;
		end
	end

endmodule

// File: test/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch
	import fetch_pkg::*;
();

	localparam int total_instr = 200;
	localparam int max_delay   = 32; // header, ack, response and stall cycles
	localparam int limit       = total_instr * max_delay + 500;

	logic        clk;
	logic        nrst;
	logic        stall;
	logic        redirect;
	logic [31:0] redirect_target;
	logic        exception_pending;
	logic [31:0] epc;
	logic [4:0]  l15_rqtype;
	logic [2:0]  l15_size;
	logic [31:0] l15_address;
	logic        l15_val;
	logic        l15_ack;
	logic        l15_header_ack;
	logic        l15_ret_val;
	logic [3:0]  l15_ret_type;
	logic [63:0] l15_ret_data_0;
	logic [63:0] l15_ret_data_1;
	logic        l15_req_ack;
	logic [31:0] instr;
	logic [31:0] instr_pc;
	logic        instr_valid;
	logic        instr_misaligned;
	int          errors;
	int          delivered;
	int          mis_count;

	integer      seed = 77;
	logic        hdr_ready;
	logic        ack_now;
	logic        ack_late;
	int          phase;    // 0 idle, 1 ack pending, 2 response pending
	int          wait_cnt;
	logic [31:0] acc_addr;
	logic [127:0] line;
	logic [31:0] word;
	logic        ret_now;
	logic        wake_req;
	logic        redir_req;
	logic        redir_br;
	logic        redir_exc;
	logic [31:0] redir_tgt;
	logic [31:0] redir_epc;
	int          cycles;
	int          err_mark;

	// header accepted only while the port presents it
	assign l15_header_ack = l15_val && hdr_ready;
	assign l15_ack        = (l15_header_ack && ack_now) || ack_late;

	fetch_frontend dut_i (.*);

	fetch_checker chk_i (.*);

	bind fetch_l15_port fetch_props props_i (.*);

	function automatic int unsigned pick(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] byte_swap(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////
	// L1.5 model and strobe driver
	////////////////////
	always @(posedge clk)
	begin
		if (nrst)
		begin
			l15_ret_val       <= 1'b0;
			ack_late          <= 1'b0;
			redirect          <= 1'b0;
			exception_pending <= 1'b0;
			hdr_ready         <= pick(3) == 0;
			ack_now           <= pick(2) == 0;
			ret_now = 1'b0;
			if (l15_header_ack)
			begin
				acc_addr = l15_address;
				phase = l15_ack ? 2 : 1;
				wait_cnt = l15_ack ? pick(6) : pick(3); // late ack within 3 cycles
			end
			else if (phase == 1)
			begin
				if (wait_cnt == 0)
				begin
					ack_late <= 1'b1;
					phase = 2;
					wait_cnt = pick(6);
				end
				else
					wait_cnt--;
			end
			else if (phase == 2)
			begin
				if (wait_cnt == 0)
				begin
					line = {$random(seed), $random(seed), $random(seed), $random(seed)};
					word = byte_swap(chk_i.mem_word(acc_addr));
					case (acc_addr[3:2])
						2'b00:   line[127:96] = word;
						2'b01:   line[95:64]  = word;
						2'b10:   line[63:32]  = word;
						default: line[31:0]   = word;
					endcase
					l15_ret_val    <= 1'b1;
					l15_ret_type   <= ret_ifill;
					l15_ret_data_0 <= line[127:64];
					l15_ret_data_1 <= line[63:0];
					ret_now = 1'b1;
					phase = 0;
				end
				else
					wait_cnt--;
			end
			if (!ret_now && wake_req)
			begin
				l15_ret_val  <= 1'b1;
				l15_ret_type <= ret_int;
				wake_req = 1'b0;
			end
			else if (!ret_now && !wake_req && pick(12) == 0)
			begin
				l15_ret_val  <= 1'b1; // store-ack noise
				l15_ret_type <= ret_st_ack;
			end
			// strobes stay clear of a completing fetch
			if (redir_req && !ret_now)
			begin
				redirect          <= redir_br;
				redirect_target   <= redir_tgt;
				exception_pending <= redir_exc;
				epc               <= redir_epc;
				redir_req = 1'b0;
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("timeout after %0d cycles, %0d instructions delivered", cycles, delivered);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic wait_delivered(input int n);
		while (delivered < n)
			@(negedge clk);
	endtask

	task automatic send_redirect(input logic br, input logic [31:0] tgt,
		input logic exc, input logic [31:0] e, input logic in_flight);
		@(negedge clk);
		while (in_flight && phase == 0)
			@(negedge clk);
		redir_br = br;
		redir_tgt = tgt;
		redir_exc = exc;
		redir_epc = e;
		redir_req = 1'b1;
		while (redir_req)
			@(negedge clk);
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, errors - err_mark);
		err_mark = errors;
	endtask

	initial
	begin
		nrst = 1'b0;
		stall = 1'b0;
		redirect = 1'b0;
		redirect_target = 32'h0;
		exception_pending = 1'b0;
		epc = 32'h0;
		l15_ret_val = 1'b0;
		l15_ret_type = ret_load;
		l15_ret_data_0 = 64'h0;
		l15_ret_data_1 = 64'h0;
		hdr_ready = 1'b0;
		ack_now = 1'b0;
		ack_late = 1'b0;
		phase = 0;
		wait_cnt = 0;
		acc_addr = 32'h0;
		wake_req = 1'b0;
		redir_req = 1'b0;
		cycles = 0;
		err_mark = 0;
		repeat (5) @(posedge clk);
		nrst <= 1'b1;

		repeat (20) @(negedge clk); // quiet port before wake
		wake_req = 1'b1;
		wait_delivered(1);
		report_test(1, "wake-up");

		wait_delivered(41);
		report_test(2, "sequential fetch");

		for (int i = 0; i < 5; i++)
		begin
			send_redirect(1'b1, 32'h4000_2000 + (pick(64) << 2), 1'b0, 32'h0, 1'b1);
			wait_delivered(delivered + 10);
		end
		report_test(3, "branch redirect");

		for (int i = 0; i < 3; i++)
		begin
			send_redirect(1'b1, 32'h4000_3000, 1'b1, 32'h4000_8000 + (pick(64) << 2), i[0]);
			wait_delivered(delivered + 10);
		end
		report_test(4, "exception over branch");

		for (int i = 0; i < 3; i++)
		begin
			send_redirect(1'b1, 32'h4000_5000 + (pick(64) << 2) + 32'd2, 1'b0, 32'h0, i[0]);
			wait_delivered(delivered + 6);
		end
		report_test(5, "misaligned target");

		for (int i = 0; i < 20; i++)
		begin
			@(posedge clk);
			stall <= 1'b1;
			repeat (pick(8) + 1) @(posedge clk);
			stall <= 1'b0;
			wait_delivered(delivered + 3);
		end
		report_test(6, "stall");

		$display("closing: %0d instructions, %0d misaligned, %0d errors",
			delivered, mis_count, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: list.f
verilog/fetch_pkg.sv
verilog/fetch_pc_unit.sv
verilog/fetch_wake_ctrl.sv
verilog/fetch_l15_port.sv
verilog/fetch_frontend.sv
test/fetch_props.sv
test/fetch_checker.sv
test/tb_fetch.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch
RTL_TOP   ?= fetch_frontend
FLIST     ?= list.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) verilog/fetch_pkg.sv \
		verilog/fetch_pc_unit.sv verilog/fetch_wake_ctrl.sv \
		verilog/fetch_l15_port.sv verilog/fetch_frontend.sv
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
